// ==== Makefile ====
# Verilator flow for the parity error logger

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_parity_err
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
common/mem_bus_pkg.sv
common/err_pkg.sv
design/parity_check/parity_check.sv
design/err_ctrl/err_ctrl.sv
design/err_capture_reg.sv
design/parity_err_top.sv
dv/parity_err_assert.sv
dv/tb_parity_err.sv

// ==== common/err_pkg.sv ====
////////////////////
// Parity error definitions
//   error source encoding
//   checker flag bundle
//   error status word
////////////////////

`default_nettype none

package err_pkg;

    // Where the last captured error came from
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,  // Nothing captured since clear
        SRC_LOCAL  = 2'd1,  // Local memory
        SRC_REMOTE = 2'd2   // Memory on the system bus
    } err_src_t;

    // Checker output, one stage after the read strobe
    typedef struct packed {
        logic       local_err;    // Local word failed parity
        logic       bus_err;      // Bus word failed parity
        logic [1:0] local_bytes;  // Failing bytes, local word
        logic [1:0] bus_bytes;    // Failing bytes, bus word
    } err_flags_t;

    // Error status word as seen by software
    typedef struct packed {
        err_src_t   src;       // Source of captured error
        logic [1:0] byte_err;  // Failing byte mask
        logic       overrun;   // Error refused while blocked
    } err_status_t;

endpackage : err_pkg

`default_nettype wire

// ==== common/mem_bus_pkg.sv ====
////////////////////
// Memory read word definitions
//   data width, byte count
//   read word with per-byte parity
////////////////////

`default_nettype none

package mem_bus_pkg;

    // Word geometry
    localparam int DATA_W    = 16;  // Data bits per word
    localparam int NUM_BYTES = 2;   // One odd-parity bit per byte

    // Word as it comes off local memory or the system bus.
    // par[0] covers data[7:0], par[1] covers data[15:8]
    typedef struct packed {
        logic [DATA_W-1:0]    data;  // Read data
        logic [NUM_BYTES-1:0] par;   // Odd parity, one bit per byte
    } mem_word_t;

endpackage : mem_bus_pkg

`default_nettype wire

// ==== design/err_capture_reg.sv ====
////////////////////
// Error holding register
//   any payload type
//   strobe load, master clear
////////////////////

`timescale 1ns/1ps
`default_nettype none

module err_capture_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     clear,  // Master clear
    input  wire logic     load,   // Capture strobe
    input  wire payload_t d,
    output payload_t      q
);

    // Zeroed by reset and master clear
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            q <= '0;
        end else if (load) begin
            q <= d;  // Hold until next strobe
        end
    end

endmodule : err_capture_reg

`default_nettype wire

// ==== design/err_ctrl/err_ctrl.sv ====
////////////////////
// Parity error control
//   block and remote-error latches
//   status and address strobes
//   parity error level, test override
////////////////////

`timescale 1ns/1ps
`default_nettype none

module err_ctrl
    import err_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       test,       // Board test mode
    input  wire logic       mclr,       // Master clear
    input  wire logic       pea_read,   // Software reads error address
    input  wire err_flags_t flags,
    input  wire logic       flags_valid,
    output logic            spes,       // Strobe error status word
    output logic            spea,       // Strobe error address
    output err_status_t     new_status,
    output logic            block,
    output logic            rerr,       // Last accepted error was remote
    output logic            parerr
);

    logic        block_q;     // Capture blocked after remote error
    logic        rerr_q;
    err_status_t held_q;      // Copy of last status sent to the register
    logic        local_hit;
    logic        bus_hit;
    logic        accept_local;
    logic        accept_bus;
    logic        refuse;

    assign local_hit = flags_valid & flags.local_err;
    assign bus_hit   = flags_valid & flags.bus_err;

    // Decision uses block from before this edge
    assign accept_local = ~block_q & local_hit;              // Local never blocks
    assign accept_bus   = ~block_q & ~local_hit & bus_hit;   // Local has priority
    assign refuse       =  block_q & (local_hit | bus_hit);  // Overrun case

    // Strobes, dead in test mode
    assign spea = ~test & (accept_local | accept_bus);
    assign spes = ~test & (accept_local | accept_bus | refuse);

    // Parity error level straight from the flag stage
    assign parerr = ~test & (local_hit | bus_hit);

    // Status word to be strobed
    always_comb begin
        new_status = held_q;
        if (accept_local) begin
            new_status.src      = SRC_LOCAL;
            new_status.byte_err = flags.local_bytes;
            new_status.overrun  = 1'b0;
        end else if (accept_bus) begin
            new_status.src      = SRC_REMOTE;
            new_status.byte_err = flags.bus_bytes;
            new_status.overrun  = 1'b0;
        end else if (refuse) begin
            new_status.overrun  = 1'b1;  // Keep source and bytes of held error
        end
    end

    // Block latch, set on remote capture, released by PEA read
    always_ff @(posedge clk) begin
        if (reset || mclr || test) begin
            block_q <= 1'b0;
        end else if (accept_bus) begin
            block_q <= 1'b1;  // Wins over a pea_read on the same edge
        end else if (pea_read) begin
            block_q <= 1'b0;
        end
    end

    // Remote error latch, cleared by next local capture
    always_ff @(posedge clk) begin
        if (reset || mclr || test) begin
            rerr_q <= 1'b0;
        end else if (accept_bus) begin
            rerr_q <= 1'b1;
        end else if (accept_local) begin
            rerr_q <= 1'b0;
        end
    end

    // Track what the status register holds
    always_ff @(posedge clk) begin
        if (reset || mclr) begin
            held_q <= '0;
        end else if (spes) begin
            held_q <= new_status;
        end
    end

    assign block = block_q & ~test;  // Reads low during test
    assign rerr  = rerr_q & ~test;

endmodule : err_ctrl

`default_nettype wire

// ==== design/parity_check/parity_check.sv ====
////////////////////
// Odd-parity checker
//   local and bus read paths
//   one register stage, address follows
////////////////////

`timescale 1ns/1ps
`default_nettype none

module parity_check
    import mem_bus_pkg::*, err_pkg::*;
#(
    parameter int ADDR_W = 24
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              loc_rd,      // Local read strobe
    input  wire mem_word_t         loc_word,
    input  wire logic [ADDR_W-1:0] loc_addr,
    input  wire logic              bus_rd,      // Bus read strobe
    input  wire mem_word_t         bus_word,
    input  wire logic [ADDR_W-1:0] bus_addr,
    output err_flags_t             flags,
    output logic      [ADDR_W-1:0] flags_addr,
    output logic                   flags_valid
);

    localparam int BYTE_W = DATA_W / NUM_BYTES;  // 8 bits per parity bit

    logic [NUM_BYTES-1:0] loc_bad;   // Raw byte failures, local
    logic [NUM_BYTES-1:0] bus_bad;   // Raw byte failures, bus
    logic [NUM_BYTES-1:0] loc_mask;  // Qualified by strobe
    logic [NUM_BYTES-1:0] bus_mask;
    err_flags_t           flags_nxt;
    logic [ADDR_W-1:0]    addr_nxt;

    // Byte plus parity bit must hold an odd number of ones
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            loc_bad[i] = ~^{loc_word.par[i], loc_word.data[i*BYTE_W +: BYTE_W]};
            bus_bad[i] = ~^{bus_word.par[i], bus_word.data[i*BYTE_W +: BYTE_W]};
        end
    end

    assign loc_mask = loc_rd ? loc_bad : '0;  // No strobe, no error
    assign bus_mask = bus_rd ? bus_bad : '0;

    always_comb begin
        flags_nxt.local_err   = |loc_mask;
        flags_nxt.bus_err     = |bus_mask;
        flags_nxt.local_bytes = loc_mask;
        flags_nxt.bus_bytes   = bus_mask;
    end

    // Address of the winning source, local first
    always_comb begin
        if (flags_nxt.local_err)     addr_nxt = loc_addr;
        else if (flags_nxt.bus_err)  addr_nxt = bus_addr;
        else if (loc_rd)             addr_nxt = loc_addr;  // Clean read
        else                         addr_nxt = bus_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags       <= '0;
            flags_valid <= 1'b0;
        end else begin
            flags       <= flags_nxt;
            flags_valid <= loc_rd | bus_rd;  // Any read this cycle
        end
    end

    // Payload, follows the flags
    always_ff @(posedge clk) begin
        flags_addr <= addr_nxt;
    end

endmodule : parity_check

`default_nettype wire

// ==== design/parity_err_top.sv ====
////////////////////
// Parity error logger top
//   checker, error control
//   status and address registers
////////////////////

`timescale 1ns/1ps
`default_nettype none

module parity_err_top
    import mem_bus_pkg::*, err_pkg::*;
#(
    parameter int ADDR_W = 24
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              test,
    input  wire logic              loc_rd,
    input  wire mem_word_t         loc_word,
    input  wire logic [ADDR_W-1:0] loc_addr,
    input  wire logic              bus_rd,
    input  wire mem_word_t         bus_word,
    input  wire logic [ADDR_W-1:0] bus_addr,
    input  wire logic              pea_read,
    input  wire logic              mclr,
    output logic                   parerr,
    output logic                   block,
    output logic                   rerr,
    output err_status_t            status,
    output logic      [ADDR_W-1:0] err_addr
);

    typedef logic [ADDR_W-1:0] addr_t;  // Address payload

    err_flags_t  flags;
    addr_t       flags_addr;
    logic        flags_valid;
    logic        spes;
    logic        spea;
    err_status_t new_status;

    parity_check #(
        .ADDR_W(ADDR_W)
    ) u_parity_check (
        .clk        (clk),
        .reset      (reset),
        .loc_rd     (loc_rd),
        .loc_word   (loc_word),
        .loc_addr   (loc_addr),
        .bus_rd     (bus_rd),
        .bus_word   (bus_word),
        .bus_addr   (bus_addr),
        .flags      (flags),
        .flags_addr (flags_addr),
        .flags_valid(flags_valid)
    );

    err_ctrl u_err_ctrl (
        .clk        (clk),
        .reset      (reset),
        .test       (test),
        .mclr       (mclr),
        .pea_read   (pea_read),
        .flags      (flags),
        .flags_valid(flags_valid),
        .spes       (spes),
        .spea       (spea),
        .new_status (new_status),
        .block      (block),
        .rerr       (rerr),
        .parerr     (parerr)
    );

    // Error status word
    err_capture_reg #(
        .payload_t(err_status_t)
    ) status_reg (
        .clk  (clk),
        .reset(reset),
        .clear(mclr),
        .load (spes),
        .d    (new_status),
        .q    (status)
    );

    // Error address
    err_capture_reg #(
        .payload_t(addr_t)
    ) addr_reg (
        .clk  (clk),
        .reset(reset),
        .clear(mclr),
        .load (spea),
        .d    (flags_addr),
        .q    (err_addr)
    );

endmodule : parity_err_top

`default_nettype wire

// ==== dv/parity_err_assert.sv ====
////////////////////
// Error control assertions
//   test mode, block and priority rules
//   bound into err_ctrl
////////////////////

`timescale 1ns/1ps
`default_nettype none

module parity_err_assert
    import err_pkg::*;
(
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        test,
    input wire logic        spes,
    input wire logic        spea,
    input wire logic        block,
    input wire logic        flags_valid,
    input wire err_flags_t  flags,
    input wire err_status_t new_status
);

    // Strobes dead in test mode
    a_test_quiet: assert property (@(posedge clk) disable iff (reset)
        test |-> !spes && !spea)
        else $error("strobe while test high");

    // Only a remote capture sets block
    a_block_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(block) |-> $past(spea && flags_valid && flags.bus_err && !flags.local_err))
        else $error("block rose without bus capture");

    a_no_capture_blocked: assert property (@(posedge clk) disable iff (reset)
        block |-> !spea)
        else $error("address strobe while blocked");

    // Local beats bus in the same cycle
    a_local_first: assert property (@(posedge clk) disable iff (reset)
        (flags_valid && flags.local_err && !block && !test) |->
            (spea && new_status.src == SRC_LOCAL))
        else $error("local error not captured first");

endmodule : parity_err_assert

bind err_ctrl parity_err_assert u_parity_err_assert (
    .clk        (clk),
    .reset      (reset),
    .test       (test),
    .spes       (spes),
    .spea       (spea),
    .block      (block),
    .flags_valid(flags_valid),
    .flags      (flags),
    .new_status (new_status)
);

`default_nettype wire

// ==== dv/tb_parity_err.sv ====
////////////////////
// Parity error logger testbench
//   LFSR stimulus, cycle model
//   compare tasks, test sequence
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_parity_err
    import mem_bus_pkg::*, err_pkg::*;
();

    localparam int ADDR_W = 24;
    typedef logic [ADDR_W-1:0] addr_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        test;
    logic        loc_rd;
    mem_word_t   loc_word;
    addr_t       loc_addr;
    logic        bus_rd;
    mem_word_t   bus_word;
    addr_t       bus_addr;
    logic        pea_read;
    logic        mclr;
    logic        parerr;
    logic        block;
    logic        rerr;
    err_status_t status;
    addr_t       err_addr;

    // Reference model of flag stage and held state
    logic        m_valid;
    logic [1:0]  m_loc_bytes;
    logic [1:0]  m_bus_bytes;
    addr_t       m_fl_addr;
    logic        m_block;
    logic        m_rerr;
    err_status_t m_status;
    addr_t       m_addr;

    logic [15:0] lfsr = 16'd40067;  // Fibonacci LFSR with taps 16 14 13 11
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    parity_err_top #(
        .ADDR_W(ADDR_W)
    ) i_dut (
        .clk     (clk),
        .reset   (reset),
        .test    (test),
        .loc_rd  (loc_rd),
        .loc_word(loc_word),
        .loc_addr(loc_addr),
        .bus_rd  (bus_rd),
        .bus_word(bus_word),
        .bus_addr(bus_addr),
        .pea_read(pea_read),
        .mclr    (mclr),
        .parerr  (parerr),
        .block   (block),
        .rerr    (rerr),
        .status  (status),
        .err_addr(err_addr)
    );

    always #50 clk = ~clk;  // 100 ns period

    // One LFSR step per bit taken with the newest bit in the LSB
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic one_in(input int n);  // Probability 1 / 2**n
        logic [31:0] r;
        r = take_bits(n);
        return r == 32'd0;
    endfunction

    function automatic logic odd_ones(input logic [8:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 9; i++) begin
            if (v[i]) n++;
        end
        return (n % 2) == 1;
    endfunction

    // Byte fails when byte plus parity bit holds an even count
    function automatic logic [1:0] bad_bytes(input mem_word_t w);
        logic [1:0] b;
        for (int i = 0; i < 2; i++) begin
            b[i] = !odd_ones({w.par[i], w.data[i*8 +: 8]});
        end
        return b;
    endfunction

    function automatic logic [1:0] rand_mask();  // Never zero
        logic [31:0] r;
        r = take_bits(2);
        return (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
    endfunction

    task automatic make_word(input logic [1:0] flip, output mem_word_t w);
        logic [31:0] r;
        r      = take_bits(16);
        w.data = r[15:0];
        w.par[0] = !odd_ones({1'b0, w.data[7:0]}) ^ flip[0];   // Good parity then flipped
        w.par[1] = !odd_ones({1'b0, w.data[15:8]}) ^ flip[1];
    endtask

    task automatic drive_local(input logic [1:0] flip, output addr_t a);
        logic [31:0] r;
        r      = take_bits(ADDR_W);
        loc_rd = 1'b1;
        make_word(flip, loc_word);
        loc_addr = r[ADDR_W-1:0];
        a        = loc_addr;
    endtask

    task automatic drive_bus(input logic [1:0] flip, output addr_t a);
        logic [31:0] r;
        r      = take_bits(ADDR_W);
        bus_rd = 1'b1;
        make_word(flip, bus_word);
        bus_addr = r[ADDR_W-1:0];
        a        = bus_addr;
    endtask

    task automatic drive_random(input logic allow_err);
        logic [1:0] fl;
        logic [1:0] fb;
        addr_t      a;
        fl = (allow_err && one_in(2)) ? rand_mask() : 2'b00;
        fb = (allow_err && one_in(2)) ? rand_mask() : 2'b00;
        if (one_in(1)) drive_local(fl, a);
        if (one_in(1)) drive_bus(fb, a);
        pea_read = one_in(3);
        if (allow_err) begin
            mclr = one_in(6);
            if (one_in(5)) test = ~test;  // Long test windows
        end
    endtask

    task automatic set_idle();
        loc_rd   = 1'b0;
        bus_rd   = 1'b0;
        pea_read = 1'b0;
        mclr     = 1'b0;
    endtask

    // Next model state from the inputs driven this cycle
    task automatic advance_model();
        logic lhit;
        logic bhit;
        logic [1:0] lb;
        logic [1:0] bb;
        lhit = m_valid && (m_loc_bytes != 2'b00);
        bhit = m_valid && (m_bus_bytes != 2'b00);
        if (test) begin
            m_block = 1'b0;  // Latches held clear
            m_rerr  = 1'b0;
        end else if (!m_block && lhit) begin
            m_status.src      = SRC_LOCAL;
            m_status.byte_err = m_loc_bytes;
            m_status.overrun  = 1'b0;
            m_addr            = m_fl_addr;
            m_rerr            = 1'b0;
        end else if (!m_block && bhit) begin
            m_status.src      = SRC_REMOTE;
            m_status.byte_err = m_bus_bytes;
            m_status.overrun  = 1'b0;
            m_addr            = m_fl_addr;
            m_rerr            = 1'b1;
            m_block           = 1'b1;  // Holds even with pea_read
        end else begin
            if (m_block && (lhit || bhit)) m_status.overrun = 1'b1;
            if (pea_read) m_block = 1'b0;
        end
        if (mclr) begin
            m_status = '0;
            m_addr   = '0;
            m_block  = 1'b0;
            m_rerr   = 1'b0;
        end
        lb          = loc_rd ? bad_bytes(loc_word) : 2'b00;
        bb          = bus_rd ? bad_bytes(bus_word) : 2'b00;
        m_valid     = loc_rd || bus_rd;
        m_loc_bytes = lb;
        m_bus_bytes = bb;
        m_fl_addr   = (lb != 2'b00) ? loc_addr : bus_addr;  // Local first
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_status(input err_status_t got, input err_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] status got %h exp %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] err_addr got %h exp %h at %0t", got, exp, $time);
        end
    endtask

    task automatic compare_model();
        check_level("parerr", parerr,
                    !test && m_valid && (m_loc_bytes != 2'b00 || m_bus_bytes != 2'b00));
        check_level("block", block, m_block && !test);
        check_level("rerr", rerr, m_rerr && !test);
        check_status(status, m_status);
        check_addr(err_addr, m_addr);
    endtask

    // Inputs already set at this falling edge
    task automatic run_cycle();
        advance_model();
        @(posedge clk);
        @(negedge clk);
        compare_model();
        set_idle();
    endtask

    task automatic wait_parerr();
        int cnt;
        cnt = 0;
        while (parerr !== 1'b1 && cnt < 8) begin
            run_cycle();
            cnt++;
        end
        if (parerr !== 1'b1) begin
            errors++;
            $display("Timed out waiting for parerr at %0t", $time);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        addr_t       a1;
        addr_t       a2;
        addr_t       a3;
        logic [1:0]  mask;
        err_status_t exp;
        int          err0;
        reset    = 1'b1;
        test     = 1'b0;
        loc_word = '0;
        loc_addr = '0;
        bus_word = '0;
        bus_addr = '0;
        set_idle();
        m_valid     = 1'b0;
        m_loc_bytes = 2'b00;
        m_bus_bytes = 2'b00;
        m_fl_addr   = '0;
        m_block     = 1'b0;
        m_rerr      = 1'b0;
        m_status    = '0;
        m_addr      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        err0 = errors;  // Clean reads
        repeat (200) begin
            drive_random(1'b0);
            run_cycle();
            check_level("parerr", parerr, 1'b0);
        end
        check_status(status, '0);
        check_addr(err_addr, '0);
        report_test("clean reads", err0);

        err0 = errors;  // Local errors
        repeat (4) begin
            mask = rand_mask();
            drive_local(mask, a1);
            run_cycle();
            wait_parerr();
            run_cycle();
            exp.src      = SRC_LOCAL;
            exp.byte_err = mask;
            exp.overrun  = 1'b0;
            check_status(status, exp);
            check_addr(err_addr, a1);
            check_level("rerr", rerr, 1'b0);
            check_level("block", block, 1'b0);
        end
        report_test("local error", err0);

        err0 = errors;  // Bus error with block, overrun and release
        mclr = 1'b1;
        run_cycle();
        mask = rand_mask();
        drive_bus(mask, a1);
        run_cycle();
        wait_parerr();
        run_cycle();
        exp.src      = SRC_REMOTE;
        exp.byte_err = mask;
        exp.overrun  = 1'b0;
        check_status(status, exp);
        check_addr(err_addr, a1);
        check_level("block", block, 1'b1);
        check_level("rerr", rerr, 1'b1);
        drive_local(rand_mask(), a2);  // Refused while blocked
        run_cycle();
        wait_parerr();
        run_cycle();
        exp.overrun = 1'b1;
        check_status(status, exp);
        check_addr(err_addr, a1);
        check_level("block", block, 1'b1);
        pea_read = 1'b1;
        run_cycle();
        check_level("block", block, 1'b0);
        mask = rand_mask();
        drive_bus(mask, a3);
        run_cycle();
        wait_parerr();
        run_cycle();
        exp.byte_err = mask;
        exp.overrun  = 1'b0;
        check_status(status, exp);
        check_addr(err_addr, a3);
        check_level("block", block, 1'b1);
        drive_bus(rand_mask(), a2);  // Second bus error also refused
        run_cycle();
        wait_parerr();
        run_cycle();
        exp.overrun = 1'b1;
        check_status(status, exp);
        check_addr(err_addr, a3);
        check_level("block", block, 1'b1);
        report_test("bus error", err0);

        err0 = errors;  // Both paths fail together
        mclr = 1'b1;
        run_cycle();
        mask = rand_mask();
        drive_local(mask, a1);
        drive_bus(rand_mask(), a2);
        run_cycle();
        wait_parerr();
        run_cycle();
        exp.src      = SRC_LOCAL;
        exp.byte_err = mask;
        exp.overrun  = 1'b0;
        check_status(status, exp);
        check_addr(err_addr, a1);
        check_level("block", block, 1'b0);
        report_test("local priority", err0);

        err0 = errors;  // Test mode then master clear
        mclr = 1'b1;
        run_cycle();
        test = 1'b1;
        repeat (6) begin
            drive_local(rand_mask(), a1);
            drive_bus(rand_mask(), a2);
            run_cycle();
            check_level("parerr", parerr, 1'b0);
            check_level("block", block, 1'b0);
            check_level("rerr", rerr, 1'b0);
        end
        run_cycle();
        run_cycle();  // Flush flag stage under test
        check_status(status, '0);
        check_addr(err_addr, '0);
        test = 1'b0;
        run_cycle();
        drive_bus(rand_mask(), a1);
        run_cycle();
        wait_parerr();
        run_cycle();
        check_level("block", block, 1'b1);
        mclr = 1'b1;
        run_cycle();
        check_status(status, '0);
        check_addr(err_addr, '0);
        check_level("block", block, 1'b0);
        check_level("rerr", rerr, 1'b0);
        report_test("test mode", err0);

        err0 = errors;  // Mixed random traffic
        repeat (2000) begin
            drive_random(1'b1);
            run_cycle();
        end
        test = 1'b0;
        run_cycle();
        report_test("random mix", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_parity_err

`default_nettype wire
